//--- src.f
+incdir+hw
hw/nn_pkg.sv
hw/stream_fifo.sv
hw/cmd_sequencer.sv
hw/window_counter.sv
hw/layer_compute_unit.sv
hw/nn_core_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/100ps -Wno-fatal \
	--top-module tb_top -f src.f

out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"

//--- dv/tb_top.sv
`include "nn_config.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_CMDS       = 40;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * 6 * `NN_WINDOW * 4 + 1000;

	logic               okClk = 1'b0;
	logic               arst_n;
	logic               cmd_valid;
	logic               cmd_ready;
	nn_pkg::cmd_word_t  cmd;
	logic               data_valid;
	logic               data_ready;
	nn_pkg::data_word_t data;
	logic               res_valid;
	logic               res_ready;
	nn_pkg::result_t    res;
	logic               op_done;
	logic               report_done;
	int                 fail_total;
	integer             seed;
	integer             data_seed;  // own stream so process order does not matter
	integer             ready_seed;

	always #2 okClk = ~okClk; // 4 ns period

	nn_core_top u_nn_core_top (
		.okClk      (okClk),
		.arst_n     (arst_n),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd        (cmd),
		.data_valid (data_valid),
		.data_ready (data_ready),
		.data       (data),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.res        (res),
		.op_done    (op_done)
	);

	tb_checker #(
		.NUM_CMDS (NUM_CMDS)
	) u_tb_checker (
		.okClk       (okClk),
		.arst_n      (arst_n),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd         (cmd),
		.data_valid  (data_valid),
		.data_ready  (data_ready),
		.data        (data),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res         (res),
		.op_done     (op_done),
		.report_done (report_done),
		.fail_total  (fail_total)
	);

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic send_commands();
		nn_pkg::cmd_word_t c;
		int                i;
		int                gap;
		bit                fired;
		for (i = 0; i < NUM_CMDS; i++) begin
			c.reserved = 14'($random(seed));
			c.op       = nn_pkg::op_e'(2'($random(seed)));
			c.op_num   = 16'($unsigned($random(seed)) % 7);
			if (i < 4) begin
				c.op = nn_pkg::op_e'(2'(i)); // each opcode at least once
			end
			if (i == 4) begin
				c.op     = nn_pkg::OP_CONV;
				c.op_num = '0; // empty command
			end
			cmd_valid = 1'b1;
			cmd       = c;
			fired     = 1'b0;
			while (!fired) begin
				@(negedge okClk);
				fired = cmd_ready; // transfer happens at the coming edge
				@(posedge okClk);
				#1;
			end
			cmd_valid = 1'b0;
			gap       = $unsigned($random(seed)) % 4;
			repeat (gap) begin
				@(posedge okClk);
				#1;
			end
		end
	endtask

	task automatic drive_data();
		bit fired;
		forever begin
			@(negedge okClk);
			fired = data_valid && data_ready;
			@(posedge okClk);
			#1;
			if (fired || !data_valid) begin
				data_valid  = (($random(data_seed) & 3) != 0); // gaps about one in four
				data.data   = 16'($random(data_seed));
				data.weight = 16'($random(data_seed));
			end
		end
	endtask

	task automatic drive_res_ready();
		int stall;
		stall = 0;
		forever begin
			@(posedge okClk);
			#1;
			if (stall > 0) begin
				res_ready = 1'b0;
				stall--;
			end else if (($random(ready_seed) & 31) == 0) begin
				stall     = 20 + ($unsigned($random(ready_seed)) % 40); // long enough to fill
				res_ready = 1'b0;
			end else begin
				res_ready = (($random(ready_seed) & 3) != 0);
			end
		end
	endtask

	initial begin
		seed       = 32'h177f;
		data_seed  = seed ^ 32'h5a5a;
		ready_seed = seed ^ 32'ha5a5;
		arst_n     = 1'b0;
		cmd_valid  = 1'b0;
		cmd        = '0;
		data_valid = 1'b0;
		data       = '0;
		res_ready  = 1'b0;
		repeat (5) @(posedge okClk);
		#1;
		arst_n = 1'b1;
		fork
			send_commands();
			drive_data();
			drive_res_ready();
		join_none
		wait (report_done);
		@(negedge okClk);
		if (fail_total == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge okClk);
		$display("timeout after %0d cycles, the checker never finished its report",
			TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- dv/tb_checker.sv
`include "nn_config.svh"

module tb_checker #(
	parameter int NUM_CMDS = 40
) (
	input  logic               okClk,
	input  logic               arst_n,
	input  logic               cmd_valid,
	input  logic               cmd_ready,
	input  nn_pkg::cmd_word_t  cmd,
	input  logic               data_valid,
	input  logic               data_ready,
	input  nn_pkg::data_word_t data,
	input  logic               res_valid,
	input  logic               res_ready,
	input  nn_pkg::result_t    res,
	input  logic               op_done,
	output logic               report_done,
	output int                 fail_total
);
	timeunit 1ns;
	timeprecision 100ps;

	nn_pkg::op_e           cmd_op    [NUM_CMDS];
	int                    exp_win   [NUM_CMDS]; // windows the command should yield
	int                    got_win   [NUM_CMDS];
	int                    cmd_errs  [NUM_CMDS];
	logic [`NN_WORD_W-1:0] exp_val_q [$];
	int                    exp_idx_q [$];        // owning command of each expected result
	logic [`NN_WORD_W-1:0] acc = '0;
	int num_cmds = 0;
	int done_cnt = 0;
	int next_report = 0;
	int dcmd = 0;
	int dwin = 0;
	int dword = 0;
	int exp_total = 0;
	int res_total = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int other_errs = 0;
	int drain = 0;
	bit released = 1'b0;

	function automatic string op_label(nn_pkg::op_e op);
		case (op)
			nn_pkg::OP_CONV:    return "conv";
			nn_pkg::OP_MAXPOOL: return "maxpool";
			nn_pkg::OP_AVEPOOL: return "avepool";
			default:            return "nop";
		endcase
	endfunction

	task automatic check_idle_outputs();
		if (res_valid || data_ready || op_done || cmd_ready) begin
			other_errs++;
			$display("outputs not idle at %0t: res_valid %b data_ready %b op_done %b",
				$time, res_valid, data_ready, op_done);
			$display("cmd_ready %b at that time", cmd_ready);
		end
	endtask

	task automatic watch_commands();
		if (cmd_valid && cmd_ready) begin
			if (num_cmds >= NUM_CMDS) begin
				other_errs++;
				$display("more commands accepted than the testbench sent");
			end else begin
				cmd_op[num_cmds]   = cmd.op;
				exp_win[num_cmds]  = (cmd.op == nn_pkg::OP_NOP) ? 0 : int'(cmd.op_num);
				got_win[num_cmds]  = 0;
				cmd_errs[num_cmds] = 0;
				exp_total += exp_win[num_cmds];
				num_cmds++;
			end
		end
	endtask

	// --------------------------------------------------
	// reference model, one window per NN_WINDOW words
	// --------------------------------------------------
	task automatic watch_data();
		logic [`NN_WORD_W-1:0] d32;
		logic [`NN_WORD_W-1:0] w32;
		if (data_valid && data_ready) begin
			while (dcmd < num_cmds && dwin >= exp_win[dcmd]) begin
				dcmd++; // skip finished and empty commands
				dwin = 0;
			end
			if (dcmd >= num_cmds) begin
				other_errs++;
				$display("data word accepted at %0t while no command has windows left", $time);
			end else begin
				d32 = {16'd0, data.data};
				w32 = {16'd0, data.weight};
				case (cmd_op[dcmd])
					nn_pkg::OP_CONV:    acc = acc + d32 * w32;
					nn_pkg::OP_MAXPOOL: acc = (d32 > acc) ? d32 : acc;
					nn_pkg::OP_AVEPOOL: acc = acc + d32;
					default:            acc = acc;
				endcase
				dword++;
				if (dword == `NN_WINDOW) begin
					exp_val_q.push_back((cmd_op[dcmd] == nn_pkg::OP_AVEPOOL) ?
						(acc >> `NN_WINDOW_LOG2) : acc);
					exp_idx_q.push_back(dcmd);
					acc   = '0;
					dword = 0;
					dwin++;
				end
			end
		end
	endtask

	task automatic watch_results();
		logic [`NN_WORD_W-1:0] val;
		int                    idx;
		if (res_valid && res_ready) begin
			res_total++;
			if (exp_val_q.size() == 0) begin
				other_errs++;
				$display("result %08h accepted at %0t with no window waiting for it",
					res.value, $time);
			end else begin
				val = exp_val_q.pop_front();
				idx = exp_idx_q.pop_front();
				if (res.op != cmd_op[idx]) begin
					cmd_errs[idx]++;
					$display("ERR test %0d window %0d op tag: expected %s actual %s",
						idx, got_win[idx], op_label(cmd_op[idx]), op_label(res.op));
				end
				if (res.value != val) begin
					cmd_errs[idx]++;
					$display("ERR test %0d window %0d value: expected %08h actual %08h",
						idx, got_win[idx], val, res.value);
				end
				got_win[idx]++;
			end
		end
	endtask

	task automatic report_finished();
		while (next_report < num_cmds && next_report < done_cnt &&
			got_win[next_report] == exp_win[next_report]) begin
			if (cmd_errs[next_report] == 0) begin
				tests_passed++;
			end else begin
				tests_failed++;
			end
			$display("test %0d %s windows %0d: %s", next_report, op_label(cmd_op[next_report]),
				exp_win[next_report], (cmd_errs[next_report] == 0) ? "pass" : "fail");
			next_report++;
		end
	endtask

	task automatic final_report();
		if (done_cnt != num_cmds) begin
			other_errs++;
			$display("op_done pulsed %0d times for %0d accepted commands", done_cnt, num_cmds);
		end
		if (res_total != exp_total) begin
			other_errs++;
			$display("%0d results came out for %0d expected windows", res_total, exp_total);
		end
		$display("summary: %0d tests passed, %0d tests failed, %0d other errors",
			tests_passed, tests_failed, other_errs);
		fail_total  = tests_failed + other_errs;
		report_done = 1'b1;
	endtask

	// sampled mid cycle, where every handshake signal is settled for the next edge
	initial begin
		report_done = 1'b0;
		fail_total  = 0;
		forever begin
			@(negedge okClk);
			if (!arst_n || !released) begin
				check_idle_outputs();
				released = arst_n;
			end
			if (arst_n) begin
				watch_commands();
				watch_data();
				watch_results();
				if (op_done) begin
					done_cnt++;
				end
				report_finished();
				if (next_report == NUM_CMDS && !report_done) begin
					drain++; // let stray results show up
					if (drain == 20) begin
						final_report();
					end
				end
			end
		end
	end

endmodule

//--- hw/nn_core_top.sv
`include "nn_config.svh"

module nn_core_top (
	input  logic               okClk,
	input  logic               arst_n,
	input  logic               cmd_valid,
	output logic               cmd_ready,
	input  nn_pkg::cmd_word_t  cmd,
	input  logic               data_valid,
	output logic               data_ready,
	input  nn_pkg::data_word_t data,
	output logic               res_valid,
	input  logic               res_ready,
	output nn_pkg::result_t    res,
	output logic               op_done
);
	logic              q_cmd_valid;
	logic              q_cmd_ready;
	nn_pkg::cmd_word_t q_cmd;
	nn_pkg::op_ctrl_t  op_ctrl;
	logic              start;
	logic              win_last;
	logic              op_last;
	logic              word_accepted;
	logic              res_accepted;
	logic              unit_res_valid;
	logic              unit_res_ready;
	nn_pkg::result_t   unit_res;

	// --------------------------------------------------
	// command path
	// --------------------------------------------------
	stream_fifo #(
		.WIDTH ($bits(nn_pkg::cmd_word_t)),
		.DEPTH (`NN_CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.in_valid  (cmd_valid),
		.in_ready  (cmd_ready),
		.in_data   (cmd),
		.out_valid (q_cmd_valid),
		.out_ready (q_cmd_ready),
		.out_data  (q_cmd)
	);

	cmd_sequencer u_cmd_sequencer (
		.okClk        (okClk),
		.arst_n       (arst_n),
		.cmd_valid    (q_cmd_valid),
		.cmd_ready    (q_cmd_ready),
		.cmd          (q_cmd),
		.op_ctrl      (op_ctrl),
		.start        (start),
		.op_last      (op_last),
		.res_accepted (res_accepted),
		.op_done      (op_done)
	);

	window_counter u_window_counter (
		.okClk         (okClk),
		.arst_n        (arst_n),
		.start         (start),
		.op_ctrl       (op_ctrl),
		.word_accepted (word_accepted),
		.res_accepted  (res_accepted),
		.win_last      (win_last),
		.op_last       (op_last)
	);

	// --------------------------------------------------
	// datapath and result buffer
	// --------------------------------------------------
	layer_compute_unit u_layer_compute_unit (
		.okClk         (okClk),
		.arst_n        (arst_n),
		.start         (start),
		.op_ctrl       (op_ctrl),
		.win_last      (win_last),
		.op_last       (op_last),
		.data_valid    (data_valid),
		.data_ready    (data_ready),
		.data          (data),
		.word_accepted (word_accepted),
		.res_valid     (unit_res_valid),
		.res_ready     (unit_res_ready),
		.res           (unit_res),
		.res_accepted  (res_accepted)
	);

	stream_fifo #(
		.WIDTH ($bits(nn_pkg::result_t)),
		.DEPTH (`NN_RES_FIFO_DEPTH)
	) u_res_fifo (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.in_valid  (unit_res_valid),
		.in_ready  (unit_res_ready),
		.in_data   (unit_res),
		.out_valid (res_valid),
		.out_ready (res_ready),
		.out_data  (res)
	);

endmodule

//--- hw/layer_compute_unit.sv
`include "nn_config.svh"

module layer_compute_unit (
	input  logic               okClk,
	input  logic               arst_n,
	input  logic               start,
	input  nn_pkg::op_ctrl_t   op_ctrl,
	input  logic               win_last,
	input  logic               op_last,
	input  logic               data_valid,
	output logic               data_ready,
	input  nn_pkg::data_word_t data,
	output logic               word_accepted,
	output logic               res_valid,
	input  logic               res_ready,
	output nn_pkg::result_t    res,
	output logic               res_accepted
);
	localparam int ACC_W = `NN_WORD_W;

	nn_pkg::op_e      op_q;
	logic             active;
	logic             pend_valid;
	logic [ACC_W-1:0] pend_value;
	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] acc_nxt;
	logic [ACC_W-1:0] data_ext;
	logic [ACC_W-1:0] prod;

	assign data_ext      = ACC_W'(data.data); // fields are unsigned
	assign prod          = data_ext * ACC_W'(data.weight);
	assign data_ready    = active && !pend_valid; // stall while a result waits
	assign word_accepted = data_valid && data_ready;
	assign res_valid     = pend_valid;
	assign res_accepted  = res_valid && res_ready;
	assign res.op        = op_q;
	assign res.value     = pend_value;

	// --------------------------------------------------
	// per-word update
	// --------------------------------------------------
	always_comb begin
		case (op_q)
			nn_pkg::OP_CONV:    acc_nxt = acc + prod;                         // wraps mod 2^32
			nn_pkg::OP_MAXPOOL: acc_nxt = (data_ext > acc) ? data_ext : acc;
			nn_pkg::OP_AVEPOOL: acc_nxt = acc + data_ext;
			default:            acc_nxt = acc;
		endcase
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			active     <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			if (start) begin
				active <= 1'b1;
			end else if (res_accepted && op_last) begin
				active <= 1'b0;
			end
			if (word_accepted && win_last) begin
				pend_valid <= 1'b1;
			end else if (res_accepted) begin
				pend_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (start) begin
			op_q <= op_ctrl.op;
			acc  <= '0;
		end else if (word_accepted) begin
			if (win_last) begin
				acc        <= '0; // next window starts clean
				pend_value <= (op_q == nn_pkg::OP_AVEPOOL) ?
					(acc_nxt >> `NN_WINDOW_LOG2) : acc_nxt;
			end else begin
				acc <= acc_nxt;
			end
		end
	end

	// a new command finds the unit idle with no result waiting
	assert property (@(posedge okClk) disable iff (!arst_n)
		(word_accepted || start) |-> !pend_valid && !(start && active));

endmodule

//--- hw/window_counter.sv
`include "nn_config.svh"

module window_counter (
	input  logic             okClk,
	input  logic             arst_n,
	input  logic             start,
	input  nn_pkg::op_ctrl_t op_ctrl,
	input  logic             word_accepted,
	input  logic             res_accepted,
	output logic             win_last,
	output logic             op_last
);
	localparam int IDX_W = `NN_WINDOW_LOG2;
	localparam int OPN_W = `NN_OPNUM_W;

	logic [IDX_W-1:0] word_idx; // position inside the current window
	logic [OPN_W-1:0] win_left; // windows not yet stored

	assign win_last = (word_idx == IDX_W'(`NN_WINDOW - 1));
	assign op_last  = (win_left == OPN_W'(1));

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			word_idx <= '0;
			win_left <= '0;
		end else if (start) begin
			word_idx <= '0;
			win_left <= op_ctrl.op_num;
		end else begin
			if (word_accepted) begin
				word_idx <= win_last ? '0 : word_idx + 1'b1;
			end
			if (res_accepted) begin
				win_left <= win_left - 1'b1; // counts down per stored result
			end
		end
	end

endmodule

//--- hw/cmd_sequencer.sv
module cmd_sequencer (
	input  logic              okClk,
	input  logic              arst_n,
	input  logic              cmd_valid,
	output logic              cmd_ready,
	input  nn_pkg::cmd_word_t cmd,
	output nn_pkg::op_ctrl_t  op_ctrl,
	output logic              start,
	input  logic              op_last,
	input  logic              res_accepted,
	output logic              op_done
);
	nn_pkg::seq_state_e state;
	nn_pkg::seq_state_e state_nxt;
	logic               run_ok;

	assign cmd_ready = (state == nn_pkg::ST_IDLE); // one command in flight at a time
	assign op_done   = (state == nn_pkg::ST_DONE);
	assign run_ok    = (op_ctrl.op != nn_pkg::OP_NOP) && (op_ctrl.op_num != '0);

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			nn_pkg::ST_IDLE: begin
				if (cmd_valid) begin
					state_nxt = nn_pkg::ST_LOAD;
				end
			end
			nn_pkg::ST_LOAD: begin
				state_nxt = run_ok ? nn_pkg::ST_RUN : nn_pkg::ST_DONE; // nop and empty skip
			end
			nn_pkg::ST_RUN: begin
				if (res_accepted && op_last) begin
					state_nxt = nn_pkg::ST_DONE; // last window stored
				end
			end
			default: begin
				state_nxt = nn_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			state <= nn_pkg::ST_IDLE;
			start <= 1'b0;
		end else begin
			state <= state_nxt;
			start <= (state == nn_pkg::ST_LOAD) && run_ok; // high in the first run cycle
		end
	end

	// FIFO head moves on at the pop edge, so capture it here
	always_ff @(posedge okClk) begin
		if (cmd_valid && cmd_ready) begin
			op_ctrl.op     <= cmd.op;
			op_ctrl.op_num <= cmd.op_num;
		end
	end

	// start and stored results belong to ST_RUN and never meet op_done
	assert property (@(posedge okClk) disable iff (!arst_n)
		(start || res_accepted) |-> (state == nn_pkg::ST_RUN) && !op_done);

endmodule

//--- hw/stream_fifo.sv
module stream_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             okClk,
	input  logic             arst_n,
	input  logic             in_valid,
	output logic             in_ready,
	input  logic [WIDTH-1:0] in_data,
	output logic             out_valid,
	input  logic             out_ready,
	output logic [WIDTH-1:0] out_data
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             up;     // low until the first edge after reset release
	logic             wr_en;
	logic             rd_en;

	assign in_ready  = up && (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr]; // head shown without a read cycle
	assign wr_en     = in_valid && in_ready;
	assign rd_en     = out_valid && out_ready;

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			up     <= 1'b0;
		end else begin
			up <= 1'b1;
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
		end
	end

	always_ff @(posedge okClk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// when full the write pointer sits on the head entry and no write may land there
	assert property (@(posedge okClk) disable iff (!arst_n)
		(count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr) && !wr_en);

endmodule

//--- hw/nn_pkg.sv
`include "nn_config.svh"

package nn_pkg;

	typedef enum logic [1:0] {
		OP_CONV    = 2'd0,
		OP_MAXPOOL = 2'd1,
		OP_AVEPOOL = 2'd2,
		OP_NOP     = 2'd3
	} op_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_RUN,
		ST_DONE
	} seq_state_e;

	// host command, opcode in the top two bits
	typedef struct packed {
		op_e                                   op;
		logic [`NN_WORD_W-`NN_OPNUM_W-3:0]     reserved; // ignored
		logic [`NN_OPNUM_W-1:0]                op_num;   // windows to process
	} cmd_word_t;

	typedef struct packed {
		logic [`NN_DATA_W-1:0] data;
		logic [`NN_DATA_W-1:0] weight;
	} data_word_t;

	typedef struct packed {
		op_e                   op;    // tag of the producing command
		logic [`NN_WORD_W-1:0] value;
	} result_t;

	typedef struct packed {
		op_e                    op;
		logic [`NN_OPNUM_W-1:0] op_num;
	} op_ctrl_t;

endpackage

//--- hw/nn_config.svh
`ifndef NN_CONFIG_SVH
`define NN_CONFIG_SVH

// datapath widths
`define NN_DATA_W         16 // data and weight fields
`define NN_WORD_W         32 // command word and result value
`define NN_OPNUM_W        16 // window count per command

// window geometry
`define NN_WINDOW         4  // input words per window
`define NN_WINDOW_LOG2    2  // average pooling shift

// buffering
`define NN_CMD_FIFO_DEPTH 8
`define NN_RES_FIFO_DEPTH 8

`endif
